// File: Bender.yml
package:
  name: l2_cache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/l2_cache_pkg.sv
      - verilog/l2_ram_512x128.sv
      - verilog/l2_data_ram.sv
      - verilog/l2_tag_ram.sv
      - verilog/l2_cache_ctrl.sv
      - verilog/l2_cache.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_clock_gen.sv
      - verif/l2_mem_model.sv
      - verif/l2_cache_tb.sv

// File: l2_cache.f
+incdir+verilog
verilog/l2_cache_pkg.sv
verilog/l2_ram_512x128.sv
verilog/l2_data_ram.sv
verilog/l2_tag_ram.sv
verilog/l2_cache_ctrl.sv
verilog/l2_cache.sv
verif/tb_clock_gen.sv
verif/l2_mem_model.sv
verif/l2_cache_tb.sv

// File: verif/l2_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defs.svh"

module l2_cache_tb
    import l2_cache_pkg::*;
();

    localparam int NUM_TRANS  = 22;   // L1 transactions over all tests
    localparam int MISS_BOUND = 40;   // cycles for a miss with write-back, with margin
    localparam int MAX_CYCLES = NUM_TRANS * MISS_BOUND + 20;
    localparam int HIT_EDGES  = 4;    // req taken on edge 1, ack seen on edge 4

    localparam logic [16:0] TAG_A  = 17'h00123;
    localparam logic [8:0]  IDX_A  = 9'h010;
    localparam logic [16:0] TAG_B  = 17'h00456;
    localparam logic [8:0]  IDX_B  = 9'h020;
    localparam logic [16:0] TAG_E0 = 17'h01000;
    localparam logic [8:0]  IDX_E  = 9'h0a0;

    logic     clk;
    logic     rst_n;
    logic     l1_req;
    l1_req_t  l1_req_data;
    logic     l1_ack;
    l1_rsp_t  l1_rsp_data;
    logic     mem_req;
    mem_req_t mem_req_data;
    logic     mem_ack;
    mem_rsp_t mem_rsp_data;
    int       mem_reads;
    int       mem_writes;
    mem_req_t last_wb;

    int seed;
    int checks = 0;
    int errors = 0;
    int tests  = 0;
    int cycles = 0;

    // every word written through L1, by word address
    logic [27:0]           shadow_addr [64];
    logic [`L2_WORD_W-1:0] shadow_data [64];
    int                    shadow_n = 0;

    tb_clock_gen #(.PERIOD(100)) u_clk (.clk(clk));

    l2_cache UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .l1_req       (l1_req),
        .l1_req_data  (l1_req_data),
        .l1_ack       (l1_ack),
        .l1_rsp_data  (l1_rsp_data),
        .mem_req      (mem_req),
        .mem_req_data (mem_req_data),
        .mem_ack      (mem_ack),
        .mem_rsp_data (mem_rsp_data)
    );

    l2_mem_model u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_req      (mem_req),
        .mem_req_data (mem_req_data),
        .mem_ack      (mem_ack),
        .mem_rsp_data (mem_rsp_data),
        .reads        (mem_reads),
        .writes       (mem_writes),
        .last_wb      (last_wb)
    );

    function automatic logic [31:0] make_addr(input logic [16:0] tag, input logic [8:0] idx,
                                              input logic [1:0] off);
        return {tag, idx, off, 4'h0};
    endfunction

    function automatic logic [`L2_WORD_W-1:0] pattern_word(input logic [25:0] line_addr,
                                                          input logic [1:0] word);
        logic [31:0] a;
        a = {6'h0, line_addr};
        return {a, a ^ 32'h0d15_ea5e, a * 32'h9e37_79b9, 32'hfeed_0000 | {30'h0, word}};
    endfunction

    function automatic logic [`L2_WORD_W-1:0] expected_word(input logic [31:0] addr);
        logic [`L2_WORD_W-1:0] w;
        w = pattern_word(addr[31:6], addr[5:4]);
        for (int i = 0; i < shadow_n; i++) begin
            if (shadow_addr[i] == addr[31:4]) begin
                w = shadow_data[i];   // later writes win
            end
        end
        return w;
    endfunction

    function automatic logic [`L2_LINE_W-1:0] expected_line(input logic [25:0] line_addr);
        logic [`L2_LINE_W-1:0] line;
        for (int w = 0; w < `L2_WORDS; w++) begin
            line[w*`L2_WORD_W +: `L2_WORD_W] = expected_word({line_addr, w[1:0], 4'h0});
        end
        return line;
    endfunction

    function automatic l1_rsp_t as_rsp(input logic [`L2_WORD_W-1:0] w);
        l1_rsp_t r;
        r.rdata = w;
        return r;
    endfunction

    function automatic logic [`L2_WORD_W-1:0] random_word();
        logic [`L2_WORD_W-1:0] w;
        for (int i = 0; i < 4; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    task automatic compare_rsp(input string name, input l1_rsp_t got, input l1_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got.rdata, exp.rdata);
        end
    endtask

    task automatic compare_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is we=%b addr=%h line=%h, expected we=%b addr=%h line=%h",
                     $time, name, got.we, got.line_addr, got.line,
                     exp.we, exp.line_addr, exp.line);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // values read just after the edge are the ones from before it
    task automatic wait_ack(input logic level, output int edges);
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
        end while (l1_ack !== level);
    endtask

    task automatic handshake(input l2_cmd_e cmd, input logic [31:0] addr,
                             input logic [`L2_WORD_W-1:0] wdata,
                             output l1_rsp_t rsp, output int edges);
        int drop_edges;
        @(posedge clk);
        l1_req_data <= '{cmd: cmd, addr: addr, wdata: wdata};
        l1_req      <= 1'b1;
        wait_ack(1'b1, edges);
        rsp = l1_rsp_data;
        l1_req <= 1'b0;
        wait_ack(1'b0, drop_edges);
    endtask

    task automatic l1_read(input logic [31:0] addr, output l1_rsp_t rsp, output int edges);
        handshake(L2_READ, addr, '0, rsp, edges);
    endtask

    task automatic l1_write(input logic [31:0] addr, input logic [`L2_WORD_W-1:0] data,
                            output int edges);
        l1_rsp_t rsp;
        shadow_addr[shadow_n] = addr[31:4];
        shadow_data[shadow_n] = data;
        shadow_n++;
        handshake(L2_WRITE, addr, data, rsp, edges);
    endtask

    task automatic read_back_line(input logic [16:0] tag, input logic [8:0] idx);
        logic [31:0] a;
        l1_rsp_t     rsp;
        int          edges;
        for (int off = 0; off < `L2_WORDS; off++) begin
            a = make_addr(tag, idx, off[1:0]);
            l1_read(a, rsp, edges);
            compare_rsp($sformatf("l1_rsp_data word %0d", off), rsp, as_rsp(expected_word(a)));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%-34s passed", name);
        end else begin
            $display("%-34s FAILED, %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic after_reset();
        int          e0;
        int          rd0;
        int          edges;
        logic [31:0] a;
        l1_rsp_t     rsp;
        e0  = errors;
        compare_bit("l1_ack", l1_ack, 1'b0);
        compare_bit("mem_req", mem_req, 1'b0);
        a   = make_addr(TAG_A, IDX_A, 2'd2);
        rd0 = mem_reads;
        l1_read(a, rsp, edges);
        compare_count("mem reads", mem_reads - rd0, 1);
        compare_count("mem writes", mem_writes, 0);
        compare_rsp("l1_rsp_data", rsp, as_rsp(expected_word(a)));
        finish_test("first read after reset", e0);
    endtask

    task automatic read_hits();
        int          e0;
        int          m0;
        int          edges;
        logic [31:0] a;
        l1_rsp_t     rsp;
        e0 = errors;
        m0 = mem_reads + mem_writes;
        for (int off = 0; off < `L2_WORDS; off++) begin
            a = make_addr(TAG_A, IDX_A, off[1:0]);
            l1_read(a, rsp, edges);
            compare_rsp("l1_rsp_data", rsp, as_rsp(expected_word(a)));
            compare_count("hit latency", edges, HIT_EDGES);
        end
        compare_count("mem requests", mem_reads + mem_writes - m0, 0);
        finish_test("read hits", e0);
    endtask

    task automatic write_hit();
        int e0;
        int m0;
        int edges;
        e0 = errors;
        m0 = mem_reads + mem_writes;
        l1_write(make_addr(TAG_A, IDX_A, 2'd1), random_word(), edges);
        compare_count("write hit latency", edges, HIT_EDGES);
        read_back_line(TAG_A, IDX_A);
        compare_count("mem requests", mem_reads + mem_writes - m0, 0);
        finish_test("write hit", e0);
    endtask

    task automatic write_miss();
        int e0;
        int rd0;
        int wr0;
        int edges;
        e0  = errors;
        rd0 = mem_reads;
        wr0 = mem_writes;
        l1_write(make_addr(TAG_B, IDX_B, 2'd3), random_word(), edges);
        read_back_line(TAG_B, IDX_B);
        compare_count("mem reads", mem_reads - rd0, 1);
        compare_count("mem writes", mem_writes - wr0, 0);
        finish_test("write miss", e0);
    endtask

    task automatic eviction();
        int          e0;
        int          rd0;
        int          wr0;
        int          edges;
        logic [31:0] a;
        l1_rsp_t     rsp;
        mem_req_t    exp_wb;
        e0  = errors;
        rd0 = mem_reads;
        wr0 = mem_writes;
        l1_write(make_addr(TAG_E0, IDX_E, 2'd0), random_word(), edges);   // way 0, dirty
        for (int i = 1; i < 5; i++) begin
            a = make_addr(TAG_E0 + i[16:0], IDX_E, 2'd0);
            l1_read(a, rsp, edges);
            compare_rsp("l1_rsp_data", rsp, as_rsp(expected_word(a)));
        end
        compare_count("mem reads", mem_reads - rd0, 5);
        compare_count("mem writes", mem_writes - wr0, 1);
        exp_wb.we        = 1'b1;
        exp_wb.line_addr = {TAG_E0, IDX_E};
        exp_wb.line      = expected_line({TAG_E0, IDX_E});
        compare_mem_req("write-back", last_wb, exp_wb);
        // refetch returns the written word, victim way 1 is clean
        for (int off = 0; off < 2; off++) begin
            a = make_addr(TAG_E0, IDX_E, off[1:0]);
            l1_read(a, rsp, edges);
            compare_rsp("l1_rsp_data", rsp, as_rsp(expected_word(a)));
        end
        compare_count("mem reads", mem_reads - rd0, 6);
        compare_count("mem writes", mem_writes - wr0, 1);
        finish_test("eviction with write-back", e0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        rst_n       = 1'b0;
        l1_req      = 1'b0;
        l1_req_data = '0;
        seed        = 27612;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        after_reset();
        read_hits();
        write_hit();
        write_miss();
        eviction();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/l2_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defs.svh"

module l2_mem_model
    import l2_cache_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     mem_req,
    input  wire mem_req_t mem_req_data,
    output logic          mem_ack,
    output mem_rsp_t      mem_rsp_data,
    output int            reads,
    output int            writes,
    output mem_req_t      last_wb
);

    logic     ack_q = 1'b0;
    mem_rsp_t rsp_q = '0;
    int       rd_n  = 0;
    int       wr_n  = 0;
    mem_req_t wb_q  = '0;

    // written-back lines, newest last
    logic [25:0]           saved_addr [32];
    logic [`L2_LINE_W-1:0] saved_line [32];

    // untouched lines hold a pattern of line address and word number
    function automatic logic [`L2_LINE_W-1:0] line_contents(input logic [25:0] la);
        logic [31:0]           a;
        logic [`L2_LINE_W-1:0] line;
        a = {6'h0, la};
        for (int w = 0; w < `L2_WORDS; w++) begin
            line[w*`L2_WORD_W +: `L2_WORD_W] =
                {a, a ^ 32'h0d15_ea5e, a * 32'h9e37_79b9, 32'hfeed_0000 + w};
        end
        for (int i = 0; i < wr_n; i++) begin
            if (saved_addr[i] == la) begin
                line = saved_line[i];
            end
        end
        return line;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            rsp_q <= '0;
            rd_n  <= 0;
            wr_n  <= 0;
            wb_q  <= '0;
        end else if (mem_req && !ack_q) begin
            ack_q <= 1'b1;
            if (mem_req_data.we) begin
                saved_addr[wr_n] <= mem_req_data.line_addr;
                saved_line[wr_n] <= mem_req_data.line;
                wb_q             <= mem_req_data;
                wr_n             <= wr_n + 1;
            end else begin
                rsp_q.line <= line_contents(mem_req_data.line_addr);
                rd_n       <= rd_n + 1;
            end
        end else if (!mem_req && ack_q) begin
            ack_q <= 1'b0;   // req dropped, close the handshake
        end
    end

    assign mem_ack      = ack_q;
    assign mem_rsp_data = rsp_q;
    assign reads        = rd_n;
    assign writes       = wr_n;
    assign last_wb      = wb_q;

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 100      // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verilog/l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defs.svh"

module l2_cache
    import l2_cache_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     l1_req,
    input  wire l1_req_t  l1_req_data,
    output logic          l1_ack,
    output l1_rsp_t       l1_rsp_data,
    output logic          mem_req,
    output mem_req_t      mem_req_data,
    input  wire logic     mem_ack,
    input  wire mem_rsp_t mem_rsp_data
);

    logic [`L2_INDEX_W-1:0]              l2_index;
    logic [`L2_OFFSET_W-1:0]             offset;
    logic [`L2_WORD_W-1:0]               l1_word;
    logic                                wd_from_mem_en;
    logic                                wd_from_l1_en;
    logic [`L2_WAYS-1:0][`L2_WORDS-1:0]  wr_en;
    logic [`L2_WAYS-1:0][`L2_LINE_W-1:0] way_rd;

    logic                  lookup;
    logic [`L2_TAG_W-1:0]  tag;
    logic                  update;
    logic [`L2_WAY_W-1:0]  update_way;
    logic                  set_dirty;
    logic                  fill;
    logic                  hit;
    logic [`L2_WAY_W-1:0]  hit_way;
    logic [`L2_WAY_W-1:0]  victim_way;
    tag_entry_t            victim;

    l2_cache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .l1_req         (l1_req),
        .l1_req_data    (l1_req_data),
        .l1_ack         (l1_ack),
        .l1_rsp_data    (l1_rsp_data),
        .mem_req        (mem_req),
        .mem_req_data   (mem_req_data),
        .mem_ack        (mem_ack),
        .l2_index       (l2_index),
        .offset         (offset),
        .l1_word        (l1_word),
        .wd_from_mem_en (wd_from_mem_en),
        .wd_from_l1_en  (wd_from_l1_en),
        .wr_en          (wr_en),
        .way_rd         (way_rd),
        .lookup         (lookup),
        .tag            (tag),
        .update         (update),
        .update_way     (update_way),
        .set_dirty      (set_dirty),
        .fill           (fill),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim         (victim)
    );

    l2_tag_ram u_tag_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup     (lookup),
        .l2_index   (l2_index),
        .tag        (tag),
        .update     (update),
        .update_way (update_way),
        .set_dirty  (set_dirty),
        .fill       (fill),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .victim     (victim)
    );

    // fill data goes straight from the memory response into the merge
    l2_data_ram u_data_ram (
        .clk            (clk),
        .l2_index       (l2_index),
        .offset         (offset),
        .mem_line       (mem_rsp_data.line),
        .l1_word        (l1_word),
        .wd_from_mem_en (wd_from_mem_en),
        .wd_from_l1_en  (wd_from_l1_en),
        .wr_en          (wr_en),
        .way_rd         (way_rd)
    );

endmodule

`default_nettype wire

// File: verilog/l2_cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defs.svh"

module l2_cache_ctrl
    import l2_cache_pkg::*;
(
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    // L1 side
    input  wire logic                                  l1_req,
    input  wire l1_req_t                               l1_req_data,
    output logic                                       l1_ack,
    output l1_rsp_t                                    l1_rsp_data,
    // memory side
    output logic                                       mem_req,
    output mem_req_t                                   mem_req_data,
    input  wire logic                                  mem_ack,
    // data RAM
    output logic      [`L2_INDEX_W-1:0]                l2_index,
    output logic      [`L2_OFFSET_W-1:0]               offset,
    output logic      [`L2_WORD_W-1:0]                 l1_word,
    output logic                                       wd_from_mem_en,
    output logic                                       wd_from_l1_en,
    output logic      [`L2_WAYS-1:0][`L2_WORDS-1:0]    wr_en,
    input  wire logic [`L2_WAYS-1:0][`L2_LINE_W-1:0]   way_rd,
    // tag RAM
    output logic                                       lookup,
    output logic      [`L2_TAG_W-1:0]                  tag,
    output logic                                       update,
    output logic      [`L2_WAY_W-1:0]                  update_way,
    output logic                                       set_dirty,
    output logic                                       fill,
    input  wire logic                                  hit,
    input  wire logic [`L2_WAY_W-1:0]                  hit_way,
    input  wire logic [`L2_WAY_W-1:0]                  victim_way,
    input  wire tag_entry_t                            victim
);

    l2_state_e state;
    logic      ack_q;
    logic      mem_req_q;
    logic [`L2_WAY_W-1:0] sel_way;      // hit way or allocated way

    l1_req_t   req_q;
    l1_rsp_t   rsp_q;
    mem_req_t  mem_q;
    mem_req_t  fetch_req;

    logic [`L2_ADDR_W-1:0] cur_addr;
    logic [`L2_WORD_W-1:0] rd_word;
    logic                  is_write;
    logic                  victim_dirty;

    // live request address while idle so the lookup starts at once
    assign cur_addr = (state == ST_IDLE) ? l1_req_data.addr : req_q.addr;
    assign l2_index = cur_addr[`L2_IDX_MSB:`L2_IDX_LSB];
    assign tag      = cur_addr[`L2_TAG_MSB:`L2_TAG_LSB];
    assign offset   = req_q.addr[`L2_OFF_MSB:`L2_OFF_LSB];
    assign l1_word  = req_q.wdata;
    assign lookup   = (state == ST_IDLE) && l1_req;

    assign is_write     = (req_q.cmd == L2_WRITE);
    assign victim_dirty = victim.valid && victim.dirty;
    assign rd_word      = way_rd[sel_way][offset*`L2_WORD_W +: `L2_WORD_W];

    assign fetch_req = '{
        we:        1'b0,
        line_addr: req_q.addr[`L2_TAG_MSB:`L2_IDX_LSB],
        line:      '0
    };

    always_comb begin
        wr_en          = '0;
        wd_from_mem_en = 1'b0;
        wd_from_l1_en  = 1'b0;
        update         = 1'b0;
        update_way     = sel_way;
        set_dirty      = 1'b0;
        fill           = 1'b0;
        case (state)
            ST_LOOKUP: begin
                if (hit && is_write) begin   // write hit, one word
                    wr_en[hit_way][offset] = 1'b1;
                    wd_from_l1_en          = 1'b1;
                    update                 = 1'b1;
                    update_way             = hit_way;
                    set_dirty              = 1'b1;
                end
            end
            ST_FETCH: begin
                if (mem_req_q && mem_ack) begin   // line valid only while ack high
                    wr_en[sel_way] = '1;
                    wd_from_mem_en = 1'b1;
                    wd_from_l1_en  = is_write;     // write-allocate merge
                    update         = 1'b1;
                    set_dirty      = is_write;
                    fill           = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            ack_q     <= 1'b0;
            mem_req_q <= 1'b0;
            sel_way   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (l1_req) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    sel_way <= hit ? hit_way : victim_way;
                    if (hit) begin
                        state <= ST_RESPOND;
                    end else begin
                        mem_req_q <= 1'b1;
                        state     <= victim_dirty ? ST_WRITEBACK : ST_FETCH;
                    end
                end
                ST_WRITEBACK: begin
                    if (mem_req_q && mem_ack) begin
                        mem_req_q <= 1'b0;
                    end else if (!mem_req_q && !mem_ack) begin
                        mem_req_q <= 1'b1;   // write-back done, start fetch
                        state     <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (mem_req_q && mem_ack) begin
                        mem_req_q <= 1'b0;
                        state     <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (!mem_ack) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    ack_q <= 1'b1;
                    state <= ST_RELEASE;
                end
                ST_RELEASE: begin
                    if (!l1_req) begin
                        ack_q <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && l1_req) begin
            req_q <= l1_req_data;
        end
        if (state == ST_RESPOND) begin
            rsp_q.rdata <= is_write ? req_q.wdata : rd_word;
        end
        if (state == ST_LOOKUP && !hit) begin
            if (victim_dirty) begin
                mem_q <= '{we: 1'b1, line_addr: {victim.tag, l2_index},
                           line: way_rd[victim_way]};
            end else begin
                mem_q <= fetch_req;
            end
        end
        if (state == ST_WRITEBACK && !mem_req_q && !mem_ack) begin
            mem_q <= fetch_req;
        end
    end

    assign l1_ack       = ack_q;
    assign l1_rsp_data  = rsp_q;
    assign mem_req      = mem_req_q;
    assign mem_req_data = mem_q;

    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req
    );

    a_rsp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        l1_ack |=> !l1_ack || $stable(l1_rsp_data)
    );

endmodule

`default_nettype wire

// File: verilog/l2_cache_defs.svh
`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

// geometry
`define L2_WAYS      4
`define L2_WAY_W     2
`define L2_SETS      512
`define L2_WORDS     4          // words per line

// widths
`define L2_WORD_W    128
`define L2_LINE_W    512
`define L2_ADDR_W    32
`define L2_INDEX_W   9
`define L2_OFFSET_W  2
`define L2_TAG_W     17

// byte address split, bits 3:0 pick the byte and are ignored
`define L2_OFF_LSB   4
`define L2_OFF_MSB   5
`define L2_IDX_LSB   6
`define L2_IDX_MSB   14
`define L2_TAG_LSB   15
`define L2_TAG_MSB   31

`endif

// File: verilog/l2_cache_pkg.sv
`default_nettype none

`include "l2_cache_defs.svh"

package l2_cache_pkg;

    typedef enum logic {
        L2_READ  = 1'b0,
        L2_WRITE = 1'b1
    } l2_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,   // dirty victim goes out first
        ST_FETCH,
        ST_FILL,        // wait for memory ack to drop
        ST_RESPOND,
        ST_RELEASE      // hold ack until L1 drops req
    } l2_state_e;

    typedef struct packed {
        l2_cmd_e                  cmd;
        logic [`L2_ADDR_W-1:0]    addr;     // byte address
        logic [`L2_WORD_W-1:0]    wdata;
    } l1_req_t;

    typedef struct packed {
        logic [`L2_WORD_W-1:0]    rdata;
    } l1_rsp_t;

    typedef struct packed {
        logic                               we;        // 1 = write-back
        logic [`L2_TAG_W+`L2_INDEX_W-1:0]   line_addr; // tag and index
        logic [`L2_LINE_W-1:0]              line;
    } mem_req_t;

    typedef struct packed {
        logic [`L2_LINE_W-1:0]    line;
    } mem_rsp_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`L2_TAG_W-1:0]     tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// File: verilog/l2_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defs.svh"

module l2_data_ram
    import l2_cache_pkg::*;
(
    input  wire logic                                      clk,
    input  wire logic [`L2_INDEX_W-1:0]                    l2_index,
    input  wire logic [`L2_OFFSET_W-1:0]                   offset,
    input  wire logic [`L2_LINE_W-1:0]                     mem_line,
    input  wire logic [`L2_WORD_W-1:0]                     l1_word,
    input  wire logic                                      wd_from_mem_en,
    input  wire logic                                      wd_from_l1_en,
    input  wire logic [`L2_WAYS-1:0][`L2_WORDS-1:0]        wr_en,   // way by word
    output logic      [`L2_WAYS-1:0][`L2_LINE_W-1:0]       way_rd
);

    logic [`L2_LINE_W-1:0] wd;          // merged write line
    logic [`L2_WAYS-1:0]   way_active;

    // memory line as the base, L1 word placed over its slot
    always_comb begin
        wd = wd_from_mem_en ? mem_line : '0;
        if (wd_from_l1_en) begin
            wd[offset*`L2_WORD_W +: `L2_WORD_W] = l1_word;
        end
    end

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            way_active[w] = |wr_en[w];
        end
    end

    // one 512x128 slice per way and word
    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        for (genvar s = 0; s < `L2_WORDS; s++) begin : g_word
            l2_ram_512x128 u_ram (
                .clk     (clk),
                .address (l2_index),
                .wren    (wr_en[w][s]),
                .data    (wd[s*`L2_WORD_W +: `L2_WORD_W]),
                .q       (way_rd[w][s*`L2_WORD_W +: `L2_WORD_W])
            );
        end
    end

    // the controller never writes two ways in one cycle
    a_way_onehot: assert property (
        @(posedge clk) disable iff ($isunknown(wr_en))
        $onehot0(way_active)
    );

endmodule

`default_nettype wire

// File: verilog/l2_ram_512x128.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defs.svh"

module l2_ram_512x128 (
    input  wire logic                   clk,
    input  wire logic [`L2_INDEX_W-1:0] address,
    input  wire logic                   wren,
    input  wire logic [`L2_WORD_W-1:0]  data,
    output logic      [`L2_WORD_W-1:0]  q
);

    logic [`L2_WORD_W-1:0] mem [`L2_SETS];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
        end
        q <= mem[address];  // read-first, old word on a write cycle
    end

endmodule

`default_nettype wire

// File: verilog/l2_tag_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defs.svh"

module l2_tag_ram
    import l2_cache_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   lookup,
    input  wire logic [`L2_INDEX_W-1:0] l2_index,
    input  wire logic [`L2_TAG_W-1:0]   tag,
    input  wire logic                   update,
    input  wire logic [`L2_WAY_W-1:0]   update_way,
    input  wire logic                   set_dirty,
    input  wire logic                   fill,
    output logic                        hit,
    output logic      [`L2_WAY_W-1:0]   hit_way,
    output logic      [`L2_WAY_W-1:0]   victim_way,
    output tag_entry_t                  victim
);

    tag_entry_t [`L2_WAYS-1:0] tags [`L2_SETS];
    logic [`L2_WAY_W-1:0]      ptr  [`L2_SETS];   // round-robin per set

    logic [`L2_WAYS-1:0]  match;
    logic [`L2_WAY_W-1:0] match_way;
    logic [`L2_WAY_W-1:0] pick;

    always_comb begin
        match_way = '0;
        pick      = ptr[l2_index];
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            match[w] = tags[l2_index][w].valid && (tags[l2_index][w].tag == tag);
            if (match[w]) begin
                match_way = w[`L2_WAY_W-1:0];
            end
            if (!tags[l2_index][w].valid) begin
                pick = w[`L2_WAY_W-1:0];   // lowest free way wins
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit        <= 1'b0;
            hit_way    <= '0;
            victim_way <= '0;
            victim     <= '0;
        end else if (lookup) begin
            hit        <= |match;
            hit_way    <= match_way;
            victim_way <= pick;
            victim     <= tags[l2_index][pick];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                tags[s] <= '0;
                ptr[s]  <= '0;
            end
        end else if (update) begin
            if (fill) begin
                tags[l2_index][update_way] <= '{valid: 1'b1, dirty: set_dirty, tag: tag};
                ptr[l2_index]              <= ptr[l2_index] + 1'b1;
            end else begin
                tags[l2_index][update_way].dirty <= set_dirty;   // mark dirty or clean
            end
        end
    end

    // a tag is only ever allocated once per set
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        lookup |-> $onehot0(match)
    );

endmodule

`default_nettype wire
